//--- Makefile
TOP = tb_data_path

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -Mdir obj_dir -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

//--- rtl/data_path.sv
`timescale 1ns/1ps
`default_nettype none

module data_path import mips_pkg::*; #(
    parameter int IM_BYTES = 256,
    parameter int DM_WORDS = 32
) (
    input  wire                    i_clock,
    input  wire                    i_rst,
    input  wire                    i_pc_enable,
    input  wire                    i_im_write_enable,
    input  wire [NB_MEM_DEPTH-1:0] i_im_address,
    input  wire [NB_MEM_WIDTH-1:0] i_im_data,
    input  wire [NB_REG-1:0]       i_rb_address,
    input  wire [NB_DM_ADDR-1:0]   i_dm_read_address,
    output logic                   o_hlt,
    output logic [NB_DATA-1:0]     o_pc_value,
    output logic [NB_DATA-1:0]     o_rb_data,
    output logic [NB_DATA-1:0]     o_dm_data
);
    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    wb_t      wb;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    logic     stall;
    logic     halted;

    fetch_stage #(
        .IM_BYTES (IM_BYTES)
    ) u_fetch_stage (
        .i_clock           (i_clock),
        .i_rst             (i_rst),
        .i_pc_enable       (i_pc_enable),
        .i_stall           (stall),
        .i_halted          (halted),
        .i_im_write_enable (i_im_write_enable),
        .i_im_address      (i_im_address),
        .i_im_data         (i_im_data),
        .o_if_id           (if_id),
        .o_pc_value        (o_pc_value)
    );

    decode_stage u_decode_stage (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_stall      (stall),
        .i_if_id      (if_id),
        .i_wb         (wb),
        .i_rb_address (i_rb_address),
        .o_id_ex      (id_ex),
        .o_halted     (halted),
        .o_rb_data    (o_rb_data)
    );

    hazard_unit u_hazard_unit (
        .i_if_id_rs (if_id.instr.r.rs),
        .i_if_id_rt (if_id.instr.r.rt),
        .i_id_ex    (id_ex),
        .i_ex_mem   (ex_mem),
        .i_wb       (wb),
        .o_fwd_a    (fwd_a),
        .o_fwd_b    (fwd_b),
        .o_stall    (stall)
    );

    execute_stage u_execute_stage (
        .i_clock   (i_clock),
        .i_rst     (i_rst),
        .i_id_ex   (id_ex),
        .i_fwd_a   (fwd_a),
        .i_fwd_b   (fwd_b),
        .i_mem_fwd (ex_mem.alu_result),
        .i_wb      (wb),
        .o_ex_mem  (ex_mem)
    );

    memory_stage #(
        .DM_WORDS (DM_WORDS)
    ) u_memory_stage (
        .i_clock           (i_clock),
        .i_rst             (i_rst),
        .i_ex_mem          (ex_mem),
        .i_dm_read_address (i_dm_read_address),
        .o_wb              (wb),
        .o_dm_data         (o_dm_data),
        .o_hlt             (o_hlt)
    );

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import mips_pkg::*; (
    input  wire                i_clock,
    input  wire                i_rst,
    input  wire                i_stall,
    input  wire  if_id_t       i_if_id,
    input  wire  wb_t          i_wb,
    input  wire  [NB_REG-1:0]  i_rb_address,
    output id_ex_t             o_id_ex,
    output logic               o_halted,
    output logic [NB_DATA-1:0] o_rb_data
);
    instr_u             instr;
    id_ex_t             dec;
    logic [NB_DATA-1:0] data_a;
    logic [NB_DATA-1:0] data_b;
    logic               halt_q;
    logic               is_hlt;

    assign instr = i_if_id.instr;

    register_bank u_register_bank (
        .i_clock      (i_clock),
        .i_rs         (instr.r.rs),
        .i_rt         (instr.r.rt),
        .i_rb_address (i_rb_address),
        .i_wb         (i_wb),
        .o_data_a     (data_a),
        .o_data_b     (data_b),
        .o_rb_data    (o_rb_data)
    );

    always_comb begin
        dec           = '0;
        dec.data_a    = data_a;
        dec.data_b    = data_b;
        dec.rs        = instr.r.rs;
        dec.rt        = instr.r.rt;
        dec.dest      = instr.i.rt;
        dec.imm       = {{16{instr.i.imm[15]}}, instr.i.imm};
        dec.alu_src   = 1'b1;
        dec.reg_write = 1'b1;
        case (instr.r.opcode)
            OP_RTYPE: begin
                dec.alu_src = 1'b0;
                dec.dest    = instr.r.rd;
                case (instr.r.funct)
                    FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_XOR:  dec.alu_op = ALU_XOR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    default: dec.reg_write = 1'b0;  // Unknown funct
                endcase
            end
            OP_ADDIU: dec.alu_op = ALU_ADD;
            OP_SLTI:  dec.alu_op = ALU_SLT;
            OP_ANDI: begin
                dec.alu_op = ALU_AND;
                dec.imm    = {16'd0, instr.i.imm};
            end
            OP_ORI: begin
                dec.alu_op = ALU_OR;
                dec.imm    = {16'd0, instr.i.imm};
            end
            OP_LW: dec.mem_read = 1'b1;     // Address add
            OP_SW: begin
                dec.mem_write = 1'b1;
                dec.reg_write = 1'b0;
            end
            OP_HLT: begin
                dec.hlt       = 1'b1;
                dec.reg_write = 1'b0;
            end
            default: dec.reg_write = 1'b0;  // Unknown opcode
        endcase
    end

    // PC must freeze in the same cycle HLT is seen
    assign is_hlt   = instr.i.opcode == OP_HLT && !halt_q;
    assign o_halted = halt_q || is_hlt;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            halt_q <= 1'b0;
        end else if (is_hlt && !i_stall) begin
            halt_q <= 1'b1;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst || i_stall || halt_q) begin
            o_id_ex <= '0;          // Bubble
        end else begin
            o_id_ex <= dec;
        end
    end

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import mips_pkg::*; (
    input  wire                i_clock,
    input  wire                i_rst,
    input  wire id_ex_t        i_id_ex,
    input  wire fwd_sel_e      i_fwd_a,
    input  wire fwd_sel_e      i_fwd_b,
    input  wire [NB_DATA-1:0]  i_mem_fwd,
    input  wire wb_t           i_wb,
    output ex_mem_t            o_ex_mem
);
    logic [NB_DATA-1:0] op_a;
    logic [NB_DATA-1:0] op_b;
    logic [NB_DATA-1:0] store_data;
    logic [NB_DATA-1:0] result;

    function automatic logic [NB_DATA-1:0] fwd_mux(input fwd_sel_e sel,
                                                   input logic [NB_DATA-1:0] reg_val);
        case (sel)
            FWD_MEM: return i_mem_fwd;
            FWD_WB:  return i_wb.data;
            default: return reg_val;
        endcase
    endfunction

    assign op_a       = fwd_mux(i_fwd_a, i_id_ex.data_a);
    assign store_data = fwd_mux(i_fwd_b, i_id_ex.data_b);
    assign op_b       = i_id_ex.alu_src ? i_id_ex.imm : store_data;

    always_comb begin
        case (i_id_ex.alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_SLT: result = {{(NB_DATA-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: result = '0;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_ex_mem <= '0;
        end else begin
            o_ex_mem.reg_write  <= i_id_ex.reg_write;
            o_ex_mem.mem_read   <= i_id_ex.mem_read;
            o_ex_mem.mem_write  <= i_id_ex.mem_write;
            o_ex_mem.hlt        <= i_id_ex.hlt;
            o_ex_mem.alu_result <= result;
            o_ex_mem.store_data <= store_data;  // Forwarded rt for sw
            o_ex_mem.dest       <= i_id_ex.dest;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import mips_pkg::*; #(
    parameter int IM_BYTES = 256
) (
    input  wire                    i_clock,
    input  wire                    i_rst,
    input  wire                    i_pc_enable,
    input  wire                    i_stall,
    input  wire                    i_halted,
    input  wire                    i_im_write_enable,
    input  wire [NB_MEM_DEPTH-1:0] i_im_address,
    input  wire [NB_MEM_WIDTH-1:0] i_im_data,
    output if_id_t                 o_if_id,
    output logic [NB_DATA-1:0]     o_pc_value
);
    localparam int NB_IM_ADDR = $clog2(IM_BYTES);

    logic [NB_MEM_WIDTH-1:0] imem [IM_BYTES];
    logic [NB_DATA-1:0]      pc;
    logic [NB_DATA-1:0]      pc_next;
    logic [NB_IM_ADDR-3:0]   word_idx;
    logic [NB_DATA-1:0]      fetch_word;
    logic                    advance;

    assign word_idx   = pc[NB_IM_ADDR-1:2];
    assign fetch_word = {imem[{word_idx, 2'd0}], imem[{word_idx, 2'd1}],
                         imem[{word_idx, 2'd2}], imem[{word_idx, 2'd3}]};  // Big-endian
    assign pc_next    = pc + NB_DATA'(4);
    assign advance    = i_pc_enable && !i_halted;
    assign o_pc_value = pc;

    always_ff @(posedge i_clock) begin
        if (i_im_write_enable) begin
            imem[i_im_address] <= i_im_data;   // Debug load
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            pc      <= '0;
            o_if_id <= '0;
        end else if (!i_stall) begin   // Stall holds PC and IF/ID
            if (advance) begin
                pc              <= pc_next;
                o_if_id.instr   <= fetch_word;
                o_if_id.pc_next <= pc_next;
            end else begin
                o_if_id <= '0;          // Bubble while idle or halted
            end
        end
    end

    a_stall_one_cycle: assert property (@(posedge i_clock) disable iff (i_rst)
        i_stall |=> !i_stall)
        else $error("Load-use stall held for more than one cycle");

endmodule

`default_nettype wire

//--- rtl/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import mips_pkg::*; (
    input  wire [NB_REG-1:0] i_if_id_rs,
    input  wire [NB_REG-1:0] i_if_id_rt,
    input  wire id_ex_t      i_id_ex,
    input  wire ex_mem_t     i_ex_mem,
    input  wire wb_t         i_wb,
    output fwd_sel_e         o_fwd_a,
    output fwd_sel_e         o_fwd_b,
    output logic             o_stall
);
    // Youngest producer wins
    function automatic fwd_sel_e pick(input logic [NB_REG-1:0] src);
        if (i_ex_mem.reg_write && i_ex_mem.dest != '0 && i_ex_mem.dest == src) begin
            return FWD_MEM;
        end
        if (i_wb.en && i_wb.dest != '0 && i_wb.dest == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign o_fwd_a = pick(i_id_ex.rs);
    assign o_fwd_b = pick(i_id_ex.rt);

    // Load result not ready until after MEM
    assign o_stall = i_id_ex.mem_read && i_id_ex.dest != '0 &&
                     (i_id_ex.dest == i_if_id_rs || i_id_ex.dest == i_if_id_rt);

    always_comb begin
        a_no_load_fwd: assert (!(i_ex_mem.mem_read &&
                                 (o_fwd_a == FWD_MEM || o_fwd_b == FWD_MEM)))
            else $error("Load result forwarded from EX/MEM before it was read");
    end

endmodule

`default_nettype wire

//--- rtl/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage import mips_pkg::*; #(
    parameter int DM_WORDS = 32
) (
    input  wire                   i_clock,
    input  wire                   i_rst,
    input  wire ex_mem_t          i_ex_mem,
    input  wire [NB_DM_ADDR-1:0]  i_dm_read_address,
    output wb_t                   o_wb,
    output logic [NB_DATA-1:0]    o_dm_data,
    output logic                  o_hlt
);
    localparam int NB_DM_IDX = $clog2(DM_WORDS);

    logic [NB_DATA-1:0]   dmem [DM_WORDS];
    logic [NB_DM_IDX-1:0] dm_idx;
    mem_wb_t              mem_wb;

    assign dm_idx = i_ex_mem.alu_result[NB_DM_IDX+1:2];   // Word address

    always_ff @(posedge i_clock) begin
        if (i_ex_mem.mem_write) begin
            dmem[dm_idx] <= i_ex_mem.store_data;
        end
        o_dm_data <= dmem[i_dm_read_address];   // Debug readback
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            mem_wb <= '0;
        end else begin
            mem_wb.reg_write  <= i_ex_mem.reg_write;
            mem_wb.mem_to_reg <= i_ex_mem.mem_read;
            mem_wb.hlt        <= i_ex_mem.hlt;
            mem_wb.mem_data   <= dmem[dm_idx];
            mem_wb.alu_result <= i_ex_mem.alu_result;
            mem_wb.dest       <= i_ex_mem.dest;
        end
    end

    assign o_wb.en   = mem_wb.reg_write;
    assign o_wb.dest = mem_wb.dest;
    assign o_wb.data = mem_wb.mem_to_reg ? mem_wb.mem_data : mem_wb.alu_result;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_hlt <= 1'b0;
        end else if (mem_wb.hlt) begin
            o_hlt <= 1'b1;          // Sticky until reset
        end
    end

    a_no_rw_overlap: assert property (@(posedge i_clock) disable iff (i_rst)
        !(i_ex_mem.mem_read && i_ex_mem.mem_write))
        else $error("Load and store in the same EX/MEM entry");

endmodule

`default_nettype wire

//--- rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int NB_DATA      = 32;
    localparam int NB_REG       = 5;
    localparam int NB_MEM_WIDTH = 8;
    localparam int NB_MEM_DEPTH = 8;    // 256 bytes
    localparam int NB_DM_ADDR   = 5;    // 32 words

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_HLT   = 6'h3f;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef struct packed {
        logic [5:0]        opcode;
        logic [NB_REG-1:0] rs;
        logic [NB_REG-1:0] rt;
        logic [NB_REG-1:0] rd;
        logic [4:0]        shamt;
        logic [5:0]        funct;
    } instr_r_t;

    typedef struct packed {
        logic [5:0]        opcode;
        logic [NB_REG-1:0] rs;
        logic [NB_REG-1:0] rt;
        logic [15:0]       imm;
    } instr_i_t;

    // Same word, two field layouts
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE,   // Register bank value
        FWD_MEM,    // EX/MEM ALU result
        FWD_WB      // Writeback data
    } fwd_sel_e;

    typedef struct packed {
        instr_u             instr;
        logic [NB_DATA-1:0] pc_next;
    } if_id_t;

    typedef struct packed {
        logic               reg_write;
        logic               mem_read;
        logic               mem_write;
        logic               alu_src;
        logic               hlt;
        alu_op_e            alu_op;
        logic [NB_DATA-1:0] data_a;
        logic [NB_DATA-1:0] data_b;
        logic [NB_DATA-1:0] imm;
        logic [NB_REG-1:0]  rs;
        logic [NB_REG-1:0]  rt;
        logic [NB_REG-1:0]  dest;
    } id_ex_t;

    typedef struct packed {
        logic               reg_write;
        logic               mem_read;
        logic               mem_write;
        logic               hlt;
        logic [NB_DATA-1:0] alu_result;
        logic [NB_DATA-1:0] store_data;
        logic [NB_REG-1:0]  dest;
    } ex_mem_t;

    typedef struct packed {
        logic               reg_write;
        logic               mem_to_reg;
        logic               hlt;
        logic [NB_DATA-1:0] mem_data;
        logic [NB_DATA-1:0] alu_result;
        logic [NB_REG-1:0]  dest;
    } mem_wb_t;

    typedef struct packed {
        logic               en;
        logic [NB_REG-1:0]  dest;
        logic [NB_DATA-1:0] data;
    } wb_t;

endpackage

`default_nettype wire

//--- rtl/register_bank.sv
`timescale 1ns/1ps
`default_nettype none

module register_bank import mips_pkg::*; (
    input  wire               i_clock,
    input  wire  [NB_REG-1:0] i_rs,
    input  wire  [NB_REG-1:0] i_rt,
    input  wire  [NB_REG-1:0] i_rb_address,
    input  wire  wb_t         i_wb,
    output logic [NB_DATA-1:0] o_data_a,
    output logic [NB_DATA-1:0] o_data_b,
    output logic [NB_DATA-1:0] o_rb_data
);
    logic [NB_DATA-1:0] regs [32];

    // Write-first: a read of the register being written sees the new value
    function automatic logic [NB_DATA-1:0] read_port(input logic [NB_REG-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (i_wb.en && i_wb.dest == addr) begin
            return i_wb.data;
        end
        return regs[addr];
    endfunction

    assign o_data_a = read_port(i_rs);
    assign o_data_b = read_port(i_rt);

    always_ff @(posedge i_clock) begin
        if (i_wb.en && i_wb.dest != '0) begin
            regs[i_wb.dest] <= i_wb.data;
        end
        o_rb_data <= read_port(i_rb_address);  // Debug readback
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+tests
rtl/mips_pkg.sv
rtl/fetch_stage.sv
rtl/register_bank.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/data_path.sv
tests/tb_data_path.sv

//--- tests/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int BODY_LEN      = 40;
localparam int TAIL_LEN      = 4;
localparam int PROG_MAX      = 64;
localparam int KIND_ALU      = 0;
localparam int KIND_LOAD_USE = 1;
localparam int KIND_MEM      = 2;
localparam int KIND_MIXED    = 3;
localparam int KIND_PRELOAD  = 4;

logic [31:0] prog [PROG_MAX];
logic [31:0] model_regs [32];
logic [31:0] model_dmem [32];
int          prog_len;
int          halt_index;

function automatic logic [31:0] rtype_word(input logic [5:0] fn, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rt,
                                           input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [4:0] rand_reg();
    return 5'($urandom_range(0, 7));
endfunction

// Base r0, so the offset is the byte address
function automatic logic [31:0] mem_word(input logic [5:0] op, input logic [4:0] rt);
    return itype_word(op, rt, 5'd0, 16'(4 * $urandom_range(0, 31)));
endfunction

function automatic logic [31:0] random_alu();
    logic [15:0] imm;
    imm = 16'($urandom);
    case ($urandom_range(0, 9))
        0: return rtype_word(FN_ADDU, rand_reg(), rand_reg(), rand_reg());
        1: return rtype_word(FN_SUBU, rand_reg(), rand_reg(), rand_reg());
        2: return rtype_word(FN_AND, rand_reg(), rand_reg(), rand_reg());
        3: return rtype_word(FN_OR, rand_reg(), rand_reg(), rand_reg());
        4: return rtype_word(FN_XOR, rand_reg(), rand_reg(), rand_reg());
        5: return rtype_word(FN_SLT, rand_reg(), rand_reg(), rand_reg());
        6: return itype_word(OP_ADDIU, rand_reg(), rand_reg(), imm);
        7: return itype_word(OP_SLTI, rand_reg(), rand_reg(), imm);
        8: return itype_word(OP_ANDI, rand_reg(), rand_reg(), imm);
        default: return itype_word(OP_ORI, rand_reg(), rand_reg(), imm);
    endcase
endfunction

function automatic logic [31:0] body_word(input int kind);
    int unsigned roll;
    roll = $urandom_range(0, 9);
    if (kind == KIND_MEM) begin
        if (roll < 4) begin
            return mem_word(OP_SW, rand_reg());
        end
        if (roll < 7) begin
            return mem_word(OP_LW, rand_reg());
        end
    end else if (kind == KIND_MIXED && roll < 4) begin
        return mem_word(roll < 2 ? OP_LW : OP_SW, rand_reg());
    end
    return random_alu();
endfunction

task automatic build_program(input int kind);
    int         idx;
    logic [4:0] dst;
    idx = 0;
    while (idx < BODY_LEN) begin
        if (kind == KIND_LOAD_USE && idx < BODY_LEN - 1) begin
            dst                  = 5'($urandom_range(1, 7));
            prog[idx]            = mem_word(OP_LW, dst);
            prog[idx + 1]        = random_alu();
            prog[idx + 1][25:21] = dst;     // Consumer right behind the load
            idx += 2;
        end else begin
            prog[idx] = body_word(kind);
            idx++;
        end
    end
    prog[BODY_LEN] = {OP_HLT, 26'd0};
    for (idx = BODY_LEN + 1; idx <= BODY_LEN + TAIL_LEN; idx++) begin
        prog[idx] = itype_word(OP_ADDIU, 5'($urandom_range(1, 7)), 5'd0,
                               16'($urandom) | 16'd1);   // Never reached
    end
    prog_len = BODY_LEN + 1 + TAIL_LEN;
endtask

// Sets every register, then fills every data word from them
task automatic preload_program();
    int k;
    for (k = 1; k < 32; k++) begin
        prog[k - 1] = itype_word(OP_ADDIU, 5'(k), 5'd0, 16'($urandom));
    end
    for (k = 0; k < 32; k++) begin
        prog[31 + k] = itype_word(OP_SW, 5'(1 + k % 31), 5'd0, 16'(4 * k));
    end
    prog[63] = {OP_HLT, 26'd0};
    prog_len = PROG_MAX;
endtask

function automatic void write_reg(input logic [4:0] dest, input logic [31:0] value);
    if (dest != 5'd0) begin
        model_regs[dest] = value;
    end
endfunction

function automatic logic [31:0] rtype_result(input logic [5:0] fn, input logic [31:0] a,
                                             input logic [31:0] b);
    case (fn)
        FN_ADDU: return a + b;
        FN_SUBU: return a - b;
        FN_AND:  return a & b;
        FN_OR:   return a | b;
        FN_XOR:  return a ^ b;
        default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
endfunction

// Plain sequential execution up to HLT
task automatic run_model();
    int          pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] sext;
    logic [31:0] addr;
    pc = 0;
    while (pc < prog_len && prog[pc][31:26] != OP_HLT) begin
        w    = prog[pc];
        a    = model_regs[w[25:21]];
        sext = {{16{w[15]}}, w[15:0]};
        addr = a + sext;
        case (w[31:26])
            OP_RTYPE: write_reg(w[15:11], rtype_result(w[5:0], a, model_regs[w[20:16]]));
            OP_ADDIU: write_reg(w[20:16], addr);
            OP_SLTI:  write_reg(w[20:16], ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0);
            OP_ANDI:  write_reg(w[20:16], a & {16'd0, w[15:0]});
            OP_ORI:   write_reg(w[20:16], a | {16'd0, w[15:0]});
            OP_LW:    write_reg(w[20:16], model_dmem[addr[6:2]]);
            OP_SW:    model_dmem[addr[6:2]] = model_regs[w[20:16]];
            default:  ;
        endcase
        pc++;
    end
    halt_index = pc;
endtask

function automatic string kind_name(input int kind);
    case (kind)
        KIND_ALU:      return "alu-only";
        KIND_LOAD_USE: return "load-use";
        KIND_MEM:      return "store/load";
        KIND_MIXED:    return "mixed";
        default:       return "preload";
    endcase
endfunction

`endif

//--- tests/tb_data_path.sv
`timescale 1ns/1ps
`default_nettype none

module tb_data_path import mips_pkg::*; ();
    localparam int RESET_CYCLES  = 16;
    localparam int HALT_TIMEOUT  = 500;
    localparam int FREEZE_CYCLES = 20;
    localparam int NUM_RANDOM    = 20;

    logic                    clock;
    logic                    rst;
    logic                    pc_enable;
    logic                    im_write_enable;
    logic [NB_MEM_DEPTH-1:0] im_address;
    logic [NB_MEM_WIDTH-1:0] im_data;
    logic [NB_REG-1:0]       rb_address;
    logic [NB_DM_ADDR-1:0]   dm_read_address;
    logic                    hlt;
    logic [NB_DATA-1:0]      pc_value;
    logic [NB_DATA-1:0]      rb_data;
    logic [NB_DATA-1:0]      dm_data;
    int                      test_errors;
    int                      failed_tests;

    `include "tb_model.svh"

    data_path #(
        .IM_BYTES (256),
        .DM_WORDS (32)
    ) UUT (
        .i_clock           (clock),
        .i_rst             (rst),
        .i_pc_enable       (pc_enable),
        .i_im_write_enable (im_write_enable),
        .i_im_address      (im_address),
        .i_im_data         (im_data),
        .i_rb_address      (rb_address),
        .i_dm_read_address (dm_read_address),
        .o_hlt             (hlt),
        .o_pc_value        (pc_value),
        .o_rb_data         (rb_data),
        .o_dm_data         (dm_data)
    );

    always #50 clock = ~clock;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, expected);
            test_errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clock);
        rst             <= 1'b1;
        pc_enable       <= 1'b0;
        im_write_enable <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        rst <= 1'b0;
        @(negedge clock);
        check_value("o_hlt", 32'(hlt), 32'd0);
        check_value("o_pc_value", pc_value, 32'd0);
    endtask

    task automatic load_program();
        int w;
        int b;
        for (w = 0; w < prog_len; w++) begin
            for (b = 0; b < 4; b++) begin
                @(posedge clock);
                im_write_enable <= 1'b1;
                im_address      <= NB_MEM_DEPTH'(4 * w + b);
                im_data         <= prog[w][31 - 8 * b -: 8];   // Big-endian bytes
            end
        end
        @(posedge clock);
        im_write_enable <= 1'b0;
    endtask

    task automatic run_to_halt();
        int          cycles;
        logic [31:0] halt_pc;
        @(posedge clock);
        pc_enable <= 1'b1;
        cycles = 0;
        @(negedge clock);
        while (!hlt && cycles < HALT_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        assert (hlt) else begin
            $display("Timeout at %0t: o_hlt did not rise within %0d cycles",
                     $time, HALT_TIMEOUT);
            test_errors++;
        end
        if (hlt) begin
            halt_pc = pc_value;
            check_value("o_pc_value", halt_pc, 32'(4 * halt_index + 4));
            repeat (FREEZE_CYCLES) begin
                @(negedge clock);
                check_value("o_pc_value", pc_value, halt_pc);   // Frozen after halt
            end
        end
    endtask

    task automatic read_back();
        int k;
        for (k = 0; k < 32; k++) begin
            @(posedge clock);
            rb_address      <= NB_REG'(k);
            dm_read_address <= NB_DM_ADDR'(k);
            @(posedge clock);
            @(negedge clock);
            check_value($sformatf("o_rb_data r%0d", k), rb_data, model_regs[k]);
            check_value($sformatf("o_dm_data word %0d", k), dm_data, model_dmem[k]);
        end
    endtask

    task automatic run_test(input int number, input int kind);
        test_errors = 0;
        if (kind == KIND_PRELOAD) begin
            preload_program();
        end else begin
            build_program(kind);
        end
        run_model();
        apply_reset();
        load_program();
        run_to_halt();
        read_back();
        $display("Test %0d (%s): %0d mismatches", number, kind_name(kind), test_errors);
        if (test_errors != 0) begin
            failed_tests++;
        end
    endtask

    initial begin
        int k;
        clock           = 1'b0;
        rst             = 1'b1;
        pc_enable       = 1'b0;
        im_write_enable = 1'b0;
        im_address      = '0;
        im_data         = '0;
        rb_address      = '0;
        dm_read_address = '0;
        failed_tests    = 0;
        for (k = 0; k < 32; k++) begin
            model_regs[k] = 32'd0;
            model_dmem[k] = 32'd0;
        end
        void'($urandom(32'h1c50e544));
        run_test(0, KIND_PRELOAD);
        for (k = 1; k <= NUM_RANDOM; k++) begin
            run_test(k, (k - 1) % 4);
        end
        $display("Tests run: %0d, with errors: %0d", NUM_RANDOM + 1, failed_tests);
        if (failed_tests == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
